// File: filelist.f
+incdir+.
defs_pkg.sv
exu_alu.sv
exu_bru.sv
exu_regfile.sv
exu.sv
exu_top.sv
tb_exu_top.sv

// File: Makefile
# Verilator build and run of the execute slice testbench.

VERILATOR ?= verilator
TOP       ?= tb_exu_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TEST RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_exu_model.svh
//**************************************************************************
// Reference model of the execute stage rules, included inside the testbench
// module after the package import.
//**************************************************************************
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

function automatic logic [31:0] alu_expected(alu_op_e op, logic [31:0] a, logic [31:0] b);
  logic [31:0] amt;
  logic        a_lt_b;
  amt    = {27'b0, b[4:0]};  // five bit shift count.
  a_lt_b = (a[31] != b[31]) ? a[31] : (a < b);
  case (op)
    alu_add:    return a + b;
    alu_sub:    return a + ~b + 32'd1;
    alu_and:    return a & b;
    alu_or:     return a | b;
    alu_xor:    return a ^ b;
    alu_sll:    return a << amt;
    alu_srl:    return a >> amt;
    alu_sra:    return (a >> amt) | ({32{a[31]}} & ~(32'hffff_ffff >> amt));
    alu_slt:    return {31'b0, a_lt_b};
    alu_sltu:   return {31'b0, a < b};
    alu_pass_b: return b;
    default:    return 32'd0;
  endcase
endfunction

function automatic logic branch_resolves(br_op_e op, logic [31:0] a, logic [31:0] b);
  logic lt_u;
  logic lt_s;
  lt_u = (a < b);
  lt_s = (a[31] ^ b[31]) ? a[31] : lt_u;  // sign bits differ.
  case (op)
    br_beq:  return a == b;
    br_bne:  return a != b;
    br_blt:  return lt_s;
    br_bge:  return !lt_s;
    br_bltu: return lt_u;
    br_bgeu: return !lt_u;
    default: return 1'b0;
  endcase
endfunction

function automatic logic is_mispredicted(logic valid, logic br, logic taken, logic predicted);
  return valid & br & (taken ^ predicted);
endfunction

function automatic logic [31:0] select_result(logic misp, logic [31:0] pc_byte, logic comp,
                                              logic [31:0] alu_val);
  if (!misp) begin
    return alu_val;
  end
  return comp ? pc_byte + 32'd2 : pc_byte + 32'd4;  // fall-through.
endfunction

`endif

// File: tb_exu_top.sv
//**************************************************************************
// Testbench for the execute slice: directed and random instructions, a
// shadow register model and a per-cycle check of the m-stage bundle.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_exu_top;

  import defs_pkg::*;

  `include "tb_exu_model.svh"

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 10;
  localparam int AluPerOp    = 20;
  localparam int BrPerCase   = 10;
  localparam int StreamLen   = 400;
  localparam int DrainCycles = 3;
  localparam int NumCycles   = 2 * 32 + 32 + 11 * AluPerOp + 12 * BrPerCase
                               + StreamLen + DrainCycles;

  logic        clk;
  logic        rst_n;
  exu_in_t     in_e;
  exu_m_t      out_m;

  integer      seed = 91;
  logic [31:0] shadow_rf [32];
  exu_m_t      exp_q [$];
  exu_m_t      wb_last;   // issued one cycle back.
  exu_m_t      wb_older;  // issued two cycles back.

  exu_top dut0 (
    .clk  (clk),
    .rst_n(rst_n),
    .in_e (in_e),
    .out_m(out_m)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  //**************************************************************************
  // stimulus helpers and shadow model
  //**************************************************************************

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic exu_in_t base_instr();
    exu_in_t     ins;
    logic [31:0] r;
    ins          = '0;
    r            = rand32();
    ins.valid    = 1'b1;
    ins.pc       = r[31:1];
    r            = rand32();
    ins.comp     = r[0];
    ins.lsu_op   = r[4:1];
    ins.rs1_addr = r[9:5];
    ins.rs2_addr = r[14:10];
    ins.rd_addr  = r[19:15];
    return ins;
  endfunction

  function automatic exu_in_t bubble();
    return '0;
  endfunction

  function automatic exu_m_t build_expected(exu_in_t ins);
    exu_m_t      m;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] pc_byte;
    logic [31:0] alu_val;
    logic        taken;
    rs1_val = shadow_rf[ins.rs1_addr];
    rs2_val = shadow_rf[ins.rs2_addr];
    pc_byte = {ins.pc, 1'b0};
    alu_val = alu_expected(ins.alu_op, ins.use_pc ? pc_byte : rs1_val,
                           ins.use_imm ? ins.imm : rs2_val);
    taken   = ins.br ? branch_resolves(ins.br_op, rs1_val, rs2_val) : 1'b0;
    m            = '0;
    m.valid      = ins.valid;
    m.comp       = ins.comp;
    m.br         = ins.br;
    m.br_ataken  = ins.br_ataken;
    m.br_misp    = is_mispredicted(ins.valid, ins.br, taken, ins.br_ataken);
    m.rd_en      = ins.rd_en;
    m.rd_addr    = ins.rd_addr;
    m.alu_res    = select_result(m.br_misp, pc_byte, ins.comp, alu_val);
    m.store_data = rs2_val;
    m.lsu        = ins.lsu;
    m.lsu_op     = ins.lsu_op;
    return m;
  endfunction

  task automatic commit_writeback(exu_m_t m);
    if (m.valid && m.rd_en && !m.lsu && (m.rd_addr != 5'd0)) begin
      shadow_rf[m.rd_addr] = m.alu_res;
    end
  endtask

  // entered and left 1 ns after a rising edge.
  task automatic issue(exu_in_t ins);
    exu_m_t exp_m;
    commit_writeback(wb_older);  // written at this edge.
    exp_m = build_expected(ins);
    exp_q.push_back(exp_m);
    wb_older = wb_last;
    wb_last  = exp_m;
    in_e     = ins;
    @(posedge clk);
    #1;
  endtask

  task automatic check_field(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    assert (got === want) else begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, want, got);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  //**************************************************************************
  // test phases
  //**************************************************************************

  task automatic preload_regs();
    exu_in_t ins;
    for (int r = 0; r < 32; r++) begin
      ins          = base_instr();
      ins.alu      = 1'b1;
      ins.alu_op   = alu_add;
      ins.use_imm  = 1'b1;
      ins.imm      = rand32();
      ins.rs1_addr = 5'd0;
      ins.rd_addr  = r[4:0];  // x0 included.
      ins.rd_en    = 1'b1;
      issue(ins);
      issue(bubble());
    end
  endtask

  task automatic read_back_regs();
    exu_in_t ins;
    for (int r = 0; r < 32; r++) begin
      ins          = base_instr();
      ins.alu      = 1'b1;
      ins.alu_op   = alu_add;
      ins.use_imm  = 1'b1;
      ins.rs1_addr = r[4:0];
      ins.rs2_addr = 5'd31 - r[4:0];  // second port via store_data.
      issue(ins);
    end
  endtask

  task automatic sweep_alu_ops();
    exu_in_t     ins;
    logic [31:0] r;
    for (int op = 0; op < 11; op++) begin
      for (int n = 0; n < AluPerOp; n++) begin
        ins         = base_instr();
        r           = rand32();
        ins.alu     = 1'b1;
        ins.alu_op  = alu_op_e'(op[3:0]);
        ins.use_imm = r[0];
        ins.use_pc  = r[1] & r[2];
        ins.rd_en   = r[3];
        ins.imm     = r[4] ? rand32() : {{27{r[5]}}, r[10:6]};
        issue(ins);
      end
    end
  endtask

  task automatic sweep_branches();
    exu_in_t     ins;
    logic [31:0] r;
    for (int op = 0; op < 6; op++) begin
      for (int p = 0; p < 2; p++) begin
        for (int n = 0; n < BrPerCase; n++) begin
          ins           = base_instr();
          r             = rand32();
          ins.br        = 1'b1;
          ins.br_op     = br_op_e'(op[2:0]);
          ins.br_ataken = p[0];
          ins.alu       = 1'b1;
          ins.alu_op    = alu_add;
          ins.use_pc    = 1'b1;
          ins.use_imm   = 1'b1;
          ins.imm       = {{20{r[31]}}, r[11:1], 1'b0};  // target offset.
          if (r[13:12] == 2'd0) begin
            ins.rs2_addr = ins.rs1_addr;
          end
          issue(ins);
        end
      end
    end
  endtask

  task automatic random_stream();
    exu_in_t     ins;
    logic [31:0] r;
    logic [4:0]  prev_rd;
    logic [4:0]  prev2_rd;
    prev_rd  = 5'd0;
    prev2_rd = 5'd0;
    for (int n = 0; n < StreamLen; n++) begin
      ins           = base_instr();
      r             = rand32();
      ins.valid     = (r[2:0] != 3'd0);
      ins.alu_op    = alu_op_e'(r[7:4] % 4'd11);
      ins.use_imm   = r[8];
      ins.use_pc    = r[9] & r[10];
      ins.imm       = rand32();
      ins.rd_en     = r[11] | r[12];
      ins.lsu       = r[13] & r[14];
      ins.alu       = !ins.lsu;
      ins.br        = r[15] & r[16] & !ins.lsu;
      ins.br_op     = br_op_e'(r[19:17] % 3'd6);
      ins.br_ataken = r[20];
      if (r[22:21] == 2'd1) begin
        ins.rs1_addr = prev_rd;  // stale operand one apart.
      end else if (r[22:21] == 2'd2) begin
        ins.rs2_addr = prev2_rd;  // new value two apart.
      end
      prev2_rd = prev_rd;
      prev_rd  = ins.rd_addr;
      issue(ins);
    end
  endtask

  //**************************************************************************
  // checker, watchdog and main sequence
  //**************************************************************************

  initial begin
    exu_m_t expected;
    forever begin
      @(negedge clk);
      if (exp_q.size() >= 2) begin
        expected = exp_q.pop_front();
      end else begin
        expected = '0;  // reset and idle.
      end
      check_field("out_m.valid", 32'(expected.valid), 32'(out_m.valid));
      check_field("out_m.comp", 32'(expected.comp), 32'(out_m.comp));
      check_field("out_m.br", 32'(expected.br), 32'(out_m.br));
      check_field("out_m.br_ataken", 32'(expected.br_ataken), 32'(out_m.br_ataken));
      check_field("out_m.br_misp", 32'(expected.br_misp), 32'(out_m.br_misp));
      check_field("out_m.rd_en", 32'(expected.rd_en), 32'(out_m.rd_en));
      check_field("out_m.rd_addr", 32'(expected.rd_addr), 32'(out_m.rd_addr));
      check_field("out_m.alu_res", expected.alu_res, out_m.alu_res);
      check_field("out_m.store_data", expected.store_data, out_m.store_data);
      check_field("out_m.lsu", 32'(expected.lsu), 32'(out_m.lsu));
      check_field("out_m.lsu_op", 32'(expected.lsu_op), 32'(out_m.lsu_op));
    end
  end

  initial begin
    #(ClkPeriod * (ResetCycles + NumCycles + 20));
    $display("watchdog expired before the instruction stream finished");
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation timeout");
  end

  initial begin
    rst_n    = 1'b0;
    in_e     = '0;
    wb_last  = '0;
    wb_older = '0;
    for (int i = 0; i < 32; i++) begin
      shadow_rf[i] = '0;
    end
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    preload_regs();
    read_back_regs();
    sweep_alu_ops();
    sweep_branches();
    random_stream();
    repeat (DrainCycles) issue(bubble());
    repeat (3) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tb_exu_top

`default_nettype wire

// File: exu_top.sv
//**************************************************************************
// Execute slice top: register file, execute control and writeback path.
// Takes one decoded instruction per cycle and returns the m-stage bundle.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module exu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  defs_pkg::exu_in_t in_e,
  output defs_pkg::exu_m_t  out_m
);

  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rf_we;

  // no writeback for loads and stores.
  assign rf_we = out_m.valid && out_m.rd_en && !out_m.lsu;

  exu_regfile regfile0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(in_e.rs1_addr),
    .rs2_addr(in_e.rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (rf_we),
    .rd_addr (out_m.rd_addr),
    .rd_data (out_m.alu_res)
  );

  exu exu0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_e    (in_e),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .out_m   (out_m)
  );

endmodule : exu_top

`default_nettype wire

// File: exu.sv
//**************************************************************************
// Execute control: operand select, branch check against the prediction,
// result choice and the register into the memory stage.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module exu (
  input  logic                     clk,
  input  logic                     rst_n,
  input  defs_pkg::exu_in_t        in_e,
  input  logic              [31:0] rs1_data,
  input  logic              [31:0] rs2_data,
  output defs_pkg::exu_m_t         out_m
);

  import defs_pkg::*;

  logic [31:0] pc_byte;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic        br_taken;
  logic        br_misp;
  logic [31:0] fall_through;
  logic [31:0] res_next;
  exu_m_t      m_next;

  //**************************************************************************
  // operands and datapath
  //**************************************************************************

  assign pc_byte = {in_e.pc, 1'b0};
  assign op_a    = in_e.use_pc ? pc_byte : rs1_data;
  assign op_b    = in_e.use_imm ? in_e.imm : rs2_data;

  exu_alu alu0 (
    .a     (op_a),
    .b     (op_b),
    .alu_op(in_e.alu_op),
    .res   (alu_out)
  );

  exu_bru bru0 (
    .en   (in_e.br),
    .br_op(in_e.br_op),
    .a    (rs1_data),
    .b    (rs2_data),
    .taken(br_taken)
  );

  //**************************************************************************
  // misprediction and result
  //**************************************************************************

  assign br_misp      = in_e.valid && in_e.br && (br_taken != in_e.br_ataken);
  assign fall_through = pc_byte + (in_e.comp ? 32'd2 : 32'd4);  // next sequential pc.
  assign res_next     = br_misp ? fall_through : alu_out;

  always_comb begin
    m_next            = '0;
    m_next.valid      = in_e.valid;
    m_next.comp       = in_e.comp;
    m_next.br         = in_e.br;
    m_next.br_ataken  = in_e.br_ataken;
    m_next.br_misp    = br_misp;
    m_next.rd_en      = in_e.rd_en;
    m_next.rd_addr    = in_e.rd_addr;
    m_next.alu_res    = res_next;
    m_next.store_data = rs2_data;
    m_next.lsu        = in_e.lsu;
    m_next.lsu_op     = in_e.lsu_op;
  end

  // e to m stage register.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_m <= '0;
    end else begin
      out_m <= m_next;
    end
  end

endmodule : exu

`default_nettype wire

// File: exu_regfile.sv
//**************************************************************************
// 32 x 32 integer register file, two async read ports and one write port.
// x0 always reads zero. No write-to-read bypass.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module exu_regfile (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [defs_pkg::RegAddrWidth-1:0] rs1_addr,
  input  logic [defs_pkg::RegAddrWidth-1:0] rs2_addr,
  output logic [                      31:0] rs1_data,
  output logic [                      31:0] rs2_data,
  input  logic                              we,
  input  logic [defs_pkg::RegAddrWidth-1:0] rd_addr,
  input  logic [                      31:0] rd_data
);

  import defs_pkg::*;

  logic [31:0] regs [2**RegAddrWidth];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**RegAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != '0)) begin  // x0 is not writable.
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule : exu_regfile

`default_nettype wire

// File: exu_bru.sv
//**************************************************************************
// Branch condition evaluator for the six RV32I conditional branches.
// Output is low whenever the enable is clear.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module exu_bru (
  input  logic                    en,
  input  defs_pkg::br_op_e        br_op,
  input  logic             [31:0] a,
  input  logic             [31:0] b,
  output logic                    taken
);

  import defs_pkg::*;

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (a == b);
  assign lt  = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    taken = 1'b0;
    if (en) begin
      case (br_op)
        br_beq:  taken = eq;
        br_bne:  taken = !eq;
        br_blt:  taken = lt;
        br_bge:  taken = !lt;
        br_bltu: taken = ltu;
        br_bgeu: taken = !ltu;
        default: taken = 1'b0;
      endcase
    end
  end

endmodule : exu_bru

`default_nettype wire

// File: exu_alu.sv
//**************************************************************************
// Combinational RV32I integer ALU used by the execute stage.
//**************************************************************************
`timescale 1ns/100ps
`default_nettype none

module exu_alu (
  input  logic               [31:0] a,
  input  logic               [31:0] b,
  input  defs_pkg::alu_op_e         alu_op,
  output logic               [31:0] res
);

  import defs_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];  // rv32 shift range.

  always_comb begin
    case (alu_op)
      alu_add:    res = a + b;
      alu_sub:    res = a - b;
      alu_and:    res = a & b;
      alu_or:     res = a | b;
      alu_xor:    res = a ^ b;
      alu_sll:    res = a << shamt;
      alu_srl:    res = a >> shamt;
      alu_sra:    res = $unsigned($signed(a) >>> shamt);
      alu_slt:    res = {31'b0, $signed(a) < $signed(b)};
      alu_sltu:   res = {31'b0, a < b};
      alu_pass_b: res = b;
      default:    res = '0;  // unused codes.
    endcase
  end

endmodule : exu_alu

`default_nettype wire

// File: defs_pkg.sv
//**************************************************************************
// Widths, operation codes and stage bundles of the RV32 execute slice.
// Imported by every RTL module and by the testbench.
//**************************************************************************
`default_nettype none

package defs_pkg;

  localparam int AluOpWidth    = 4;
  localparam int BranchOpWidth = 3;
  localparam int LsuOpWidth    = 4;
  localparam int RegAddrWidth  = 5;

  //**************************************************************************
  // operation codes
  //**************************************************************************

  typedef enum logic [AluOpWidth-1:0] {
    alu_add    = 4'h0,
    alu_sub    = 4'h1,
    alu_and    = 4'h2,
    alu_or     = 4'h3,
    alu_xor    = 4'h4,
    alu_sll    = 4'h5,
    alu_srl    = 4'h6,
    alu_sra    = 4'h7,
    alu_slt    = 4'h8,
    alu_sltu   = 4'h9,
    alu_pass_b = 4'ha   // lui.
  } alu_op_e;

  typedef enum logic [BranchOpWidth-1:0] {
    br_beq  = 3'h0,
    br_bne  = 3'h1,
    br_blt  = 3'h2,
    br_bge  = 3'h3,
    br_bltu = 3'h4,
    br_bgeu = 3'h5
  } br_op_e;

  //**************************************************************************
  // stage bundles
  //**************************************************************************

  // decoded instruction entering execute.
  typedef struct packed {
    logic                    valid;
    logic [31:1]             pc;         // half-word address.
    logic                    comp;       // compressed.
    logic                    br;
    logic                    br_ataken;  // predicted taken.
    br_op_e                  br_op;
    logic                    alu;
    alu_op_e                 alu_op;
    logic                    use_imm;
    logic                    use_pc;
    logic [31:0]             imm;
    logic [RegAddrWidth-1:0] rs1_addr;
    logic [RegAddrWidth-1:0] rs2_addr;
    logic [RegAddrWidth-1:0] rd_addr;
    logic                    rd_en;
    logic                    lsu;
    logic [LsuOpWidth-1:0]   lsu_op;     // carried only.
  } exu_in_t;

  // memory-stage bundle leaving execute.
  typedef struct packed {
    logic                    valid;
    logic                    comp;
    logic                    br;
    logic                    br_ataken;
    logic                    br_misp;
    logic                    rd_en;
    logic [RegAddrWidth-1:0] rd_addr;
    logic [31:0]             alu_res;
    logic [31:0]             store_data;
    logic                    lsu;
    logic [LsuOpWidth-1:0]   lsu_op;
  } exu_m_t;

endpackage : defs_pkg

`default_nettype wire
